/* compile.f */
+incdir+dv
source/du_map_pkg.sv
source/rv_pipe_pkg.sv
source/du_access_fsm.sv
source/du_regs.sv
source/du_bp_match.sv
source/du_trap_capture.sv
source/du_halt_ctrl.sv
source/riscv_du.sv
dv/tb_riscv_du.sv

/* run.sh */
#!/bin/sh
# Build the debug unit testbench with Verilator and run it

cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module tb_riscv_du &&
  ./obj_dir/Vtb_riscv_du | tee /dev/stderr | grep -qx "test passed" &&
  echo "simulation result: PASS" ||
  { echo "simulation result: FAIL"; exit 1; }

/* dv/du_tb_tasks.svh */
/*
  Debug unit testbench helpers
  - host port access with acknowledge timeout
  - compare tasks on the DUT types
  - directed tests for map, breakpoints, cause and halt
*/
`ifndef DU_TB_TASKS_SVH
`define DU_TB_TASKS_SVH

localparam int ACK_TIMEOUT = 16;

////////////////////////////////////////
// Stimulus helpers
task automatic tick();
  @(posedge clk_i);
  #2;
endtask

function automatic du_dbg_addr_t bank_addr(input du_bank_t bank, input du_reg_addr_t a);
  return {bank, a};
endfunction

function automatic du_dbg_addr_t int_addr(input du_reg_addr_t a);
  return bank_addr(DBG_INTERNAL, a);
endfunction

// Slot n control, or data when sel_data is set
function automatic du_dbg_addr_t bp_addr(input int n, input logic sel_data);
  return int_addr(du_reg_addr_t'(DBG_BPCTRL0 + 2 * n + int'(sel_data)));
endfunction

function automatic xlen_t bp_ctrl_word(input logic enabled, input du_cc_t cc);
  return {25'h0, cc, 2'b00, enabled, 1'b0};
endfunction

function automatic insn_t make_insn(input logic [4:0] opc, input logic bubble);
  insn_t insn;
  insn.bubble = bubble;
  insn.instr  = {25'h0, opc, 2'b11};
  return insn;
endfunction

////////////////////////////////////////
// Compare tasks
task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
  n_checks++;
  if (got !== exp)
  begin
    n_errors++;
    $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  n_checks++;
  if (got !== exp)
  begin
    n_errors++;
    $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_exc(input string name, input exc_vec_t got, input exc_vec_t exp);
  n_checks++;
  if (got !== exp)
  begin
    n_errors++;
    $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
  end
endtask

////////////////////////////////////////
// Host port
task automatic bus_access(input logic we, input du_dbg_addr_t addr, input xlen_t wdata,
                          output xlen_t rdata, output logic acked);
  int n;
  rdata      = '0;
  acked      = 1'b0;
  dbg_strb_i = 1'b1;
  dbg_we_i   = we;
  dbg_addr_i = addr;
  dbg_d_i    = wdata;
  for (n = 0; n < ACK_TIMEOUT && !acked; n++)
  begin
    tick();
    if (dbg_ack_o)
    begin
      acked = 1'b1;
      rdata = dbg_q_o;
    end
  end
  // Strobe low for one cycle between accesses
  dbg_strb_i = 1'b0;
  dbg_we_i   = 1'b0;
  tick();
endtask

task automatic dbg_write(input du_dbg_addr_t addr, input xlen_t data);
  xlen_t rd;
  logic  acked;
  bus_access(1'b1, addr, data, rd, acked);
  if (!acked)
  begin
    n_errors++;
    $display("write to address %h got no acknowledge within %0d cycles", addr, ACK_TIMEOUT);
  end
endtask

task automatic dbg_read(input du_dbg_addr_t addr, output xlen_t data);
  logic acked;
  bus_access(1'b0, addr, '0, data, acked);
  if (!acked)
  begin
    n_errors++;
    $display("read from address %h got no acknowledge within %0d cycles", addr, ACK_TIMEOUT);
  end
endtask

task automatic expect_reg(input string name, input du_dbg_addr_t addr, input xlen_t exp);
  xlen_t rd;
  dbg_read(addr, rd);
  check_xlen({"dbg_q_o ", name}, rd, exp);
endtask

task automatic wait_bp();
  int n;
  for (n = 0; n < 8 && !dbg_bp_o; n++)
    tick();
  if (!dbg_bp_o)
  begin
    n_errors++;
    $display("dbg_bp_o did not rise within 8 cycles of the hit");
  end
endtask

// Observe a memory stage access for one cycle, then read and clear HIT
task automatic mem_probe(input string name, input logic [4:0] opc, input logic bubble,
                         input xlen_t adr, input logic ack, input logic exc, input bp_vec_t exp);
  mem_i.insn = make_insn(opc, bubble);
  mem_i.adr  = adr;
  mem_i.ack  = ack;
  mem_i.exc  = exc;
  tick();
  mem_i.ack  = 1'b0;
  expect_reg(name, int_addr(DBG_HIT), xlen_t'(exp) << 4);
  dbg_write(int_addr(DBG_HIT), '0);
endtask

task automatic exc_pulse(input exc_vec_t vec, input xlen_t wb_pc);
  pipe_pc_i.wb_pc = wb_pc;
  du_exceptions_i = vec;
  tick();
  du_exceptions_i = '0;
endtask

// Count the entry and exit pulses over a few cycles
task automatic set_stall(input logic level, output int n_latch, output int n_flush);
  int n;
  n_latch     = 0;
  n_flush     = 0;
  dbg_stall_i = level;
  for (n = 0; n < 6; n++)
  begin
    @(negedge clk_i);
    if (du_latch_nxt_pc_o)
      n_latch++;
    if (du_flush_o)
      n_flush++;
  end
  tick();
endtask

////////////////////////////////////////
// Directed tests
task automatic test_reset_map();
  xlen_t rd;
  logic  acked;
  int    n;
  expect_reg("CTRL", int_addr(DBG_CTRL), '0);
  expect_reg("HIT", int_addr(DBG_HIT), '0);
  expect_reg("IE", int_addr(DBG_IE), '0);
  expect_reg("CAUSE", int_addr(DBG_CAUSE), '0);
  // Slot 3 lies in the map but is not implemented
  for (n = 0; n <= BREAKPOINTS; n++)
    expect_reg("BPCTRL", bp_addr(n, 1'b0), (n < BREAKPOINTS) ? 32'h1 : 32'h0);
  // GPR bank while the CPU runs
  bus_access(1'b0, bank_addr(DBG_GPRS, DBG_PPC), '0, rd, acked);
  check_bit("dbg_ack_o", acked, 1'b0);
endtask

task automatic test_readback();
  xlen_t val;
  int    n;
  val = $urandom();
  dbg_write(int_addr(DBG_IE), val);
  expect_reg("IE", int_addr(DBG_IE), val);
  check_exc("du_ie_o", du_ie_o, exc_vec_t'(val));
  for (n = 0; n < BREAKPOINTS; n++)
  begin
    val = $urandom();
    dbg_write(bp_addr(n, 1'b1), val);
    expect_reg("BPDATA", bp_addr(n, 1'b1), val);
    val = $urandom();
    dbg_write(bp_addr(n, 1'b0), val);
    expect_reg("BPCTRL", bp_addr(n, 1'b0), (val & 32'h72) | 32'h1);
    dbg_write(bp_addr(n, 1'b0), '0);
  end
  val = $urandom();
  dbg_write(int_addr(DBG_CTRL), val);
  expect_reg("CTRL", int_addr(DBG_CTRL), val & 32'h3);
  dbg_write(int_addr(DBG_CTRL), '0);
endtask

task automatic test_fetch_bp();
  xlen_t pc;
  pc = ($urandom() & 32'hFFFF_FFFC) | 32'h100;
  dbg_write(bp_addr(0, 1'b1), pc);
  dbg_write(bp_addr(0, 1'b0), bp_ctrl_word(1'b1, BP_CC_FETCH));
  pipe_pc_i.pd_pc = pc;
  wait_bp();
  check_bit("du_stall_if_o", du_stall_if_o, 1'b1);
  pipe_pc_i.pd_pc = pc + 32'h4;
  expect_reg("HIT fetch", int_addr(DBG_HIT), 32'h10);
  dbg_write(int_addr(DBG_HIT), '0);
  expect_reg("HIT cleared", int_addr(DBG_HIT), '0);
  // Matching PC during a branch flush
  bu_flush_i      = 1'b1;
  pipe_pc_i.pd_pc = pc;
  expect_reg("HIT flushed", int_addr(DBG_HIT), '0);
  bu_flush_i      = 1'b0;
  pipe_pc_i.pd_pc = pc + 32'h4;
  dbg_write(bp_addr(0, 1'b0), '0);
endtask

task automatic test_mem_bp();
  xlen_t ld_adr;
  xlen_t st_adr;
  ld_adr = $urandom() & 32'hFFFF_FFFC;
  st_adr = ld_adr ^ 32'h100;
  dbg_write(bp_addr(1, 1'b1), ld_adr);
  dbg_write(bp_addr(1, 1'b0), bp_ctrl_word(1'b1, BP_CC_LD_ADR));
  dbg_write(bp_addr(2, 1'b1), st_adr);
  dbg_write(bp_addr(2, 1'b0), bp_ctrl_word(1'b1, BP_CC_ST_ADR));
  mem_probe("HIT load", OPC_LOAD, 1'b0, ld_adr, 1'b1, 1'b0, 3'b010);
  mem_probe("HIT store", OPC_STORE, 1'b0, st_adr, 1'b1, 1'b0, 3'b100);
  mem_probe("HIT store on load bp", OPC_STORE, 1'b0, ld_adr, 1'b1, 1'b0, 3'b000);
  mem_probe("HIT load on store bp", OPC_LOAD, 1'b0, st_adr, 1'b1, 1'b0, 3'b000);
  mem_probe("HIT bubble", OPC_LOAD, 1'b1, ld_adr, 1'b1, 1'b0, 3'b000);
  mem_probe("HIT exception", OPC_LOAD, 1'b0, ld_adr, 1'b1, 1'b1, 3'b000);
  mem_probe("HIT no ack", OPC_LOAD, 1'b0, ld_adr, 1'b0, 1'b0, 3'b000);
  mem_probe("HIT branch", OPC_BRANCH, 1'b0, st_adr, 1'b1, 1'b0, 3'b000);
  mem_i = '0;
  dbg_write(bp_addr(1, 1'b0), '0);
  dbg_write(bp_addr(2, 1'b0), '0);
endtask

task automatic test_cause();
  exc_vec_t vec;
  xlen_t    wb;
  int       k;
  // Halt first, so the entry latch is over before the traps
  dbg_stall_i = 1'b1;
  tick();
  tick();
  k        = int'($urandom() % 16);
  wb       = $urandom();
  vec      = '0;
  vec.trap = 16'h8000 | (16'h1 << k);
  exc_pulse(vec, wb);
  expect_reg("CAUSE trap", int_addr(DBG_CAUSE), xlen_t'(k));
  expect_reg("PPC trap", bank_addr(DBG_GPRS, DBG_PPC), wb);
  k        = int'($urandom() % 16);
  wb       = $urandom();
  vec      = '0;
  vec.irq  = 16'h8000 | (16'h1 << k);
  exc_pulse(vec, wb);
  expect_reg("CAUSE interrupt", int_addr(DBG_CAUSE), 32'h8000_0000 | xlen_t'(k));
  expect_reg("PPC interrupt", bank_addr(DBG_GPRS, DBG_PPC), wb);
  dbg_stall_i = 1'b0;
  tick();
  tick();
endtask

task automatic test_step_halt();
  xlen_t cause;
  int    n_latch;
  int    n_flush;
  dbg_write(int_addr(DBG_CTRL), 32'h1);
  if_nxt_insn_i = make_insn(OPC_LOAD, 1'b0);
  tick();
  if_nxt_insn_i.bubble = 1'b1;
  expect_reg("HIT step", int_addr(DBG_HIT), 32'h1);
  dbg_write(int_addr(DBG_CTRL), 32'h2);
  dbg_write(int_addr(DBG_HIT), '0);
  if_insn_i = make_insn(OPC_LOAD, 1'b0);
  tick();
  if_insn_i.bubble = 1'b1;
  expect_reg("HIT non-branch", int_addr(DBG_HIT), '0);
  if_insn_i = make_insn(OPC_BRANCH, 1'b0);
  tick();
  if_insn_i.bubble = 1'b1;
  expect_reg("HIT branch", int_addr(DBG_HIT), 32'h2);
  dbg_write(int_addr(DBG_CTRL), '0);
  dbg_write(int_addr(DBG_HIT), '0);

  // Debug entry and exit
  cause = $urandom() | 32'h1;
  dbg_write(int_addr(DBG_CAUSE), cause);
  expect_reg("CAUSE written", int_addr(DBG_CAUSE), cause);
  set_stall(1'b1, n_latch, n_flush);
  check_xlen("du_latch_nxt_pc_o pulses on entry", xlen_t'(n_latch), 32'h1);
  check_xlen("du_flush_o pulses on entry", xlen_t'(n_flush), 32'h0);
  check_bit("du_stall_o", du_stall_o, 1'b1);
  set_stall(1'b0, n_latch, n_flush);
  check_xlen("du_latch_nxt_pc_o pulses on exit", xlen_t'(n_latch), 32'h0);
  check_xlen("du_flush_o pulses on exit", xlen_t'(n_flush), 32'h1);
  expect_reg("CAUSE after flush", int_addr(DBG_CAUSE), '0);
endtask

`endif

/* dv/tb_riscv_du.sv */
/*
  Testbench for the RISC-V debug unit
  - clock and reset generation
  - DUT instance with all inputs defaulted
  - directed test sequence and closing report
*/
`timescale 1ns/1ps

module tb_riscv_du;
  import du_map_pkg::*;
  import rv_pipe_pkg::*;

  logic         clk_i;
  logic         rst_ni;
  logic         dbg_stall_i;
  logic         dbg_strb_i;
  logic         dbg_we_i;
  du_dbg_addr_t dbg_addr_i;
  xlen_t        dbg_d_i;
  xlen_t        dbg_q_o;
  logic         dbg_ack_o;
  logic         dbg_bp_o;
  logic         du_stall_o;
  logic         du_stall_if_o;
  logic         du_latch_nxt_pc_o;
  logic         du_flush_o;
  exc_vec_t     du_ie_o;
  pipe_pc_t     pipe_pc_i;
  insn_t        if_nxt_insn_i;
  insn_t        if_insn_i;
  mem_obs_t     mem_i;
  exc_vec_t     du_exceptions_i;
  logic         ex_stall_i;
  logic         bu_flush_i;
  logic         st_flush_i;

  int n_checks;
  int n_errors;

  riscv_du u_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dbg_stall_i       (dbg_stall_i),
    .dbg_strb_i        (dbg_strb_i),
    .dbg_we_i          (dbg_we_i),
    .dbg_addr_i        (dbg_addr_i),
    .dbg_d_i           (dbg_d_i),
    .dbg_q_o           (dbg_q_o),
    .dbg_ack_o         (dbg_ack_o),
    .dbg_bp_o          (dbg_bp_o),
    .du_stall_o        (du_stall_o),
    .du_stall_if_o     (du_stall_if_o),
    .du_latch_nxt_pc_o (du_latch_nxt_pc_o),
    .du_flush_o        (du_flush_o),
    .du_ie_o           (du_ie_o),
    .pipe_pc_i         (pipe_pc_i),
    .if_nxt_insn_i     (if_nxt_insn_i),
    .if_insn_i         (if_insn_i),
    .mem_i             (mem_i),
    .du_exceptions_i   (du_exceptions_i),
    .ex_stall_i        (ex_stall_i),
    .bu_flush_i        (bu_flush_i),
    .st_flush_i        (st_flush_i)
  );

  `include "du_tb_tasks.svh"

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Test sequence
  initial
  begin
    void'($urandom(39496));
    n_checks        = 0;
    n_errors        = 0;
    rst_ni          = 1'b0;
    dbg_stall_i     = 1'b0;
    dbg_strb_i      = 1'b0;
    dbg_we_i        = 1'b0;
    dbg_addr_i      = '0;
    dbg_d_i         = '0;
    pipe_pc_i       = '0;
    // Idle pipeline shows bubbles
    if_nxt_insn_i   = make_insn(OPC_LOAD, 1'b1);
    if_insn_i       = make_insn(OPC_LOAD, 1'b1);
    mem_i           = '0;
    du_exceptions_i = '0;
    ex_stall_i      = 1'b0;
    bu_flush_i      = 1'b0;
    st_flush_i      = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    tick();

    test_reset_map();
    test_readback();
    test_fetch_bp();
    test_mem_bp();
    test_cause();
    test_step_halt();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* source/riscv_du.sv */
/*
  RISC-V debug unit top level
  - host port sequencer and internal register bank
  - breakpoint matching, trap capture and halt control
*/
`timescale 1ns/1ps

module riscv_du (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dbg_stall_i,
  input  logic                     dbg_strb_i,
  input  logic                     dbg_we_i,
  input  du_map_pkg::du_dbg_addr_t dbg_addr_i,
  input  du_map_pkg::xlen_t        dbg_d_i,
  output du_map_pkg::xlen_t        dbg_q_o,
  output logic                     dbg_ack_o,
  output logic                     dbg_bp_o,
  output logic                     du_stall_o,
  output logic                     du_stall_if_o,
  output logic                     du_latch_nxt_pc_o,
  output logic                     du_flush_o,
  output du_map_pkg::exc_vec_t     du_ie_o,
  input  rv_pipe_pkg::pipe_pc_t    pipe_pc_i,
  input  rv_pipe_pkg::insn_t       if_nxt_insn_i,
  input  rv_pipe_pkg::insn_t       if_insn_i,
  input  rv_pipe_pkg::mem_obs_t    mem_i,
  input  du_map_pkg::exc_vec_t     du_exceptions_i,
  input  logic                     ex_stall_i,
  input  logic                     bu_flush_i,
  input  logic                     st_flush_i
);
  import du_map_pkg::*;

  du_wr_t                     wr;
  xlen_t                      int_rdata;
  xlen_t                      cause;
  xlen_t                      dpc;
  logic                       instr_ena;
  logic                       branch_ena;
  bp_ctrl_t [BREAKPOINTS-1:0] bp_ctrl;
  xlen_t    [BREAKPOINTS-1:0] bp_data;
  logic                       any_hit;
  logic                       instr_hit;
  logic                       branch_hit;
  bp_vec_t                    bp_hit;

  ////////////////////////////////////////
  // Host side
  du_access_fsm u_access (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dbg_stall_i (dbg_stall_i),
    .dbg_strb_i  (dbg_strb_i),
    .dbg_we_i    (dbg_we_i),
    .dbg_addr_i  (dbg_addr_i),
    .dbg_d_i     (dbg_d_i),
    .ex_stall_i  (ex_stall_i),
    .int_rdata_i (int_rdata),
    .npc_i       (pipe_pc_i.if_nxt_pc),
    .dpc_i       (dpc),
    .wr_o        (wr),
    .dbg_q_o     (dbg_q_o),
    .dbg_ack_o   (dbg_ack_o)
  );

  du_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_i         (wr),
    .rd_addr_i    (dbg_addr_i[DU_ADDR_SIZE-1:0]),
    .cause_i      (cause),
    .instr_hit_i  (instr_hit),
    .branch_hit_i (branch_hit),
    .bp_hit_i     (bp_hit),
    .instr_ena_o  (instr_ena),
    .branch_ena_o (branch_ena),
    .bp_ctrl_o    (bp_ctrl),
    .bp_data_o    (bp_data),
    .ie_o         (du_ie_o),
    .any_hit_o    (any_hit),
    .rd_data_o    (int_rdata)
  );

  ////////////////////////////////////////
  // CPU side
  du_bp_match u_match (
    .instr_ena_i   (instr_ena),
    .branch_ena_i  (branch_ena),
    .bp_ctrl_i     (bp_ctrl),
    .bp_data_i     (bp_data),
    .pd_pc_i       (pipe_pc_i.pd_pc),
    .if_nxt_insn_i (if_nxt_insn_i),
    .if_insn_i     (if_insn_i),
    .mem_i         (mem_i),
    .bu_flush_i    (bu_flush_i),
    .st_flush_i    (st_flush_i),
    .instr_hit_o   (instr_hit),
    .branch_hit_o  (branch_hit),
    .bp_hit_o      (bp_hit)
  );

  du_trap_capture u_trap (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_i         (wr),
    .exceptions_i (du_exceptions_i),
    .flush_i      (du_flush_o),
    .latch_i      (du_latch_nxt_pc_o),
    .instr_hit_i  (instr_hit),
    .branch_hit_i (branch_hit),
    .bp_hit_i     (bp_hit),
    .pipe_pc_i    (pipe_pc_i),
    .cause_o      (cause),
    .dpc_o        (dpc)
  );

  du_halt_ctrl u_halt (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dbg_stall_i       (dbg_stall_i),
    .any_hit_i         (any_hit),
    .exceptions_i      (du_exceptions_i),
    .ex_stall_i        (ex_stall_i),
    .st_flush_i        (st_flush_i),
    .du_stall_o        (du_stall_o),
    .du_stall_if_o     (du_stall_if_o),
    .du_latch_nxt_pc_o (du_latch_nxt_pc_o),
    .du_flush_o        (du_flush_o),
    .dbg_bp_o          (dbg_bp_o)
  );

endmodule

/* source/du_halt_ctrl.sv */
/*
  Halt control towards the CPU and host
  - stall pass-through and fetch stall
  - latch and flush pulses on debug entry and exit
  - registered breakpoint signal
*/
`timescale 1ns/1ps

module du_halt_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 dbg_stall_i,
  input  logic                 any_hit_i,
  input  du_map_pkg::exc_vec_t exceptions_i,
  input  logic                 ex_stall_i,
  input  logic                 st_flush_i,
  output logic                 du_stall_o,
  output logic                 du_stall_if_o,
  output logic                 du_latch_nxt_pc_o,
  output logic                 du_flush_o,
  output logic                 dbg_bp_o
);
  logic stall_q;

  assign du_stall_o    = dbg_stall_i;
  assign du_stall_if_o = dbg_stall_i | any_hit_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stall_q  <= 1'b0;
      dbg_bp_o <= 1'b0;
    end
    else
    begin
      stall_q  <= dbg_stall_i;
      dbg_bp_o <= ~ex_stall_i & ~du_flush_o & ~st_flush_i & ((|exceptions_i) | any_hit_i);
    end
  end

  // Entry latches the next PC, exit flushes the pipe
  assign du_latch_nxt_pc_o = dbg_stall_i & ~stall_q;
  assign du_flush_o        = ~dbg_stall_i & stall_q;

endmodule

/* source/du_trap_capture.sv */
/*
  Trap cause and debug PC capture
  - cause register with trap/interrupt priority encoding
  - debug PC latched from the stage that raised the event
*/
`timescale 1ns/1ps

module du_trap_capture (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  du_map_pkg::du_wr_t     wr_i,
  input  du_map_pkg::exc_vec_t   exceptions_i,
  input  logic                   flush_i,
  input  logic                   latch_i,
  input  logic                   instr_hit_i,
  input  logic                   branch_hit_i,
  input  du_map_pkg::bp_vec_t    bp_hit_i,
  input  rv_pipe_pkg::pipe_pc_t  pipe_pc_i,
  output du_map_pkg::xlen_t      cause_o,
  output du_map_pkg::xlen_t      dpc_o
);
  import du_map_pkg::*;

  logic any_exc;

  // Lowest set bit wins
  function automatic logic [3:0] lowest_set(input logic [15:0] vec);
    logic [3:0] idx;
    idx = '0;
    for (int i = 15; i >= 0; i--)
      if (vec[i]) idx = 4'(i);
    return idx;
  endfunction

  assign any_exc = |exceptions_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cause_o <= '0;
    else if (wr_i.we && wr_i.addr == DBG_CAUSE)
      cause_o <= wr_i.data;
    else if (flush_i && !any_exc)
      cause_o <= '0;
    else if (|exceptions_i.trap)
      cause_o <= xlen_t'(lowest_set(exceptions_i.trap));
    else if (|exceptions_i.irq)
      cause_o <= {1'b1, {(XLEN-5){1'b0}}, lowest_set(exceptions_i.irq)};
  end

  // Each trigger is seen at a different pipeline stage
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dpc_o <= '0;
    else if (any_exc)
      dpc_o <= pipe_pc_i.wb_pc;
    else if (instr_hit_i)
      dpc_o <= pipe_pc_i.if_nxt_pc;
    else if (|bp_hit_i || branch_hit_i)
      dpc_o <= pipe_pc_i.id_pc;
    else if (latch_i && cause_o == '0)
      dpc_o <= pipe_pc_i.id_pc;
  end

endmodule

/* source/du_bp_match.sv */
/*
  Breakpoint hit detection, combinational
  - single-step and branch-break triggers
  - fetch PC and load/store address compare per breakpoint
*/
`timescale 1ns/1ps

module du_bp_match (
  input  logic                                              instr_ena_i,
  input  logic                                              branch_ena_i,
  input  du_map_pkg::bp_ctrl_t [du_map_pkg::BREAKPOINTS-1:0] bp_ctrl_i,
  input  du_map_pkg::xlen_t    [du_map_pkg::BREAKPOINTS-1:0] bp_data_i,
  input  du_map_pkg::xlen_t                                 pd_pc_i,
  input  rv_pipe_pkg::insn_t                                if_nxt_insn_i,
  input  rv_pipe_pkg::insn_t                                if_insn_i,
  input  rv_pipe_pkg::mem_obs_t                             mem_i,
  input  logic                                              bu_flush_i,
  input  logic                                              st_flush_i,
  output logic                                              instr_hit_o,
  output logic                                              branch_hit_o,
  output du_map_pkg::bp_vec_t                               bp_hit_o
);
  import du_map_pkg::*;
  import rv_pipe_pkg::*;

  logic mem_valid;
  logic mem_read;
  logic mem_write;

  assign instr_hit_o  = instr_ena_i & ~if_nxt_insn_i.bubble;
  assign branch_hit_o = branch_ena_i & ~if_insn_i.bubble & (opcode(if_insn_i) == OPC_BRANCH);

  // Completed data access without a trap
  assign mem_valid = mem_i.ack & ~mem_i.insn.bubble & ~mem_i.exc;
  assign mem_read  = mem_valid & (opcode(mem_i.insn) == OPC_LOAD);
  assign mem_write = mem_valid & (opcode(mem_i.insn) == OPC_STORE);

  always_comb
  begin
    for (int n = 0; n < BREAKPOINTS; n++)
    begin
      bp_hit_o[n] = 1'b0;
      if (bp_ctrl_i[n].enabled)
        case (bp_ctrl_i[n].cc)
          BP_CC_FETCH:    bp_hit_o[n] = (pd_pc_i == bp_data_i[n]) & ~bu_flush_i & ~st_flush_i;
          BP_CC_LD_ADR:   bp_hit_o[n] = (mem_i.adr == bp_data_i[n]) & mem_read;
          BP_CC_ST_ADR:   bp_hit_o[n] = (mem_i.adr == bp_data_i[n]) & mem_write;
          BP_CC_LDST_ADR: bp_hit_o[n] = (mem_i.adr == bp_data_i[n]) & (mem_read | mem_write);
          default:        bp_hit_o[n] = 1'b0;
        endcase
    end
  end

endmodule

/* source/du_regs.sv */
/*
  Internal debug register bank
  - control and interrupt-enable registers
  - sticky hit flags, host write takes precedence
  - breakpoint control and data registers
  - read mux for the internal bank
*/
`timescale 1ns/1ps

module du_regs (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  du_map_pkg::du_wr_t                                wr_i,
  input  du_map_pkg::du_reg_addr_t                          rd_addr_i,
  input  du_map_pkg::xlen_t                                 cause_i,
  input  logic                                              instr_hit_i,
  input  logic                                              branch_hit_i,
  input  du_map_pkg::bp_vec_t                               bp_hit_i,
  output logic                                              instr_ena_o,
  output logic                                              branch_ena_o,
  output du_map_pkg::bp_ctrl_t [du_map_pkg::BREAKPOINTS-1:0] bp_ctrl_o,
  output du_map_pkg::xlen_t    [du_map_pkg::BREAKPOINTS-1:0] bp_data_o,
  output du_map_pkg::exc_vec_t                              ie_o,
  output logic                                              any_hit_o,
  output du_map_pkg::xlen_t                                 rd_data_o
);
  import du_map_pkg::*;

  logic                               instr_hit_q;
  logic                               branch_hit_q;
  bp_vec_t                            bp_hit_q;
  du_reg_addr_t                       wr_offs;
  du_reg_addr_t                       rd_offs;
  logic [$clog2(MAX_BREAKPOINTS)-1:0] wr_idx;
  logic [$clog2(MAX_BREAKPOINTS)-1:0] rd_idx;
  logic                               wr_bp;
  logic                               rd_bp;

  ////////////////////////////////////////
  // Breakpoint slot decode
  // Slot n at BPCTRL0 + 2n, data in the odd word
  assign wr_offs = wr_i.addr - DBG_BPCTRL0;
  assign rd_offs = rd_addr_i - DBG_BPCTRL0;
  assign wr_idx  = wr_offs[1 +: $clog2(MAX_BREAKPOINTS)];
  assign rd_idx  = rd_offs[1 +: $clog2(MAX_BREAKPOINTS)];

  // Only implemented slots are writable
  assign wr_bp = wr_i.we && (wr_i.addr >= DBG_BPCTRL0)
               && (wr_offs < du_reg_addr_t'(2 * MAX_BREAKPOINTS))
               && (wr_idx < BREAKPOINTS);
  assign rd_bp = (rd_addr_i >= DBG_BPCTRL0)
               && (rd_offs < du_reg_addr_t'(2 * MAX_BREAKPOINTS));

  ////////////////////////////////////////
  // Registers
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      instr_ena_o  <= 1'b0;
      branch_ena_o <= 1'b0;
      ie_o         <= '0;
    end
    else if (wr_i.we)
    begin
      if (wr_i.addr == DBG_CTRL)
      begin
        instr_ena_o  <= wr_i.data[0];
        branch_ena_o <= wr_i.data[1];
      end
      if (wr_i.addr == DBG_IE)
        ie_o <= wr_i.data[31:0];
    end
  end

  // Hit flags stay set until the host clears them
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      instr_hit_q  <= 1'b0;
      branch_hit_q <= 1'b0;
      bp_hit_q     <= '0;
    end
    else if (wr_i.we && wr_i.addr == DBG_HIT)
    begin
      instr_hit_q  <= wr_i.data[0];
      branch_hit_q <= wr_i.data[1];
      bp_hit_q     <= wr_i.data[4 +: BREAKPOINTS];
    end
    else
    begin
      instr_hit_q  <= instr_hit_q | instr_hit_i;
      branch_hit_q <= branch_hit_q | branch_hit_i;
      bp_hit_q     <= bp_hit_q | bp_hit_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bp_ctrl_o <= '0;
      bp_data_o <= '0;
    end
    else if (wr_bp && wr_offs[0])
      bp_data_o[wr_idx] <= wr_i.data;
    else if (wr_bp)
    begin
      bp_ctrl_o[wr_idx].enabled <= wr_i.data[1];
      bp_ctrl_o[wr_idx].cc      <= du_cc_t'(wr_i.data[6:4]);
    end
  end

  assign any_hit_o = instr_hit_q | branch_hit_q | (|bp_hit_q);

  ////////////////////////////////////////
  // Read mux
  always_comb
  begin
    rd_data_o = '0;
    case (rd_addr_i)
      DBG_CTRL:  rd_data_o = xlen_t'({branch_ena_o, instr_ena_o});
      DBG_HIT:   rd_data_o = xlen_t'({bp_hit_q, 2'b00, branch_hit_q, instr_hit_q});
      DBG_IE:    rd_data_o = xlen_t'(ie_o);
      DBG_CAUSE: rd_data_o = cause_i;
      default:
        // Slots past BREAKPOINTS read as zero
        if (rd_bp && rd_idx < BREAKPOINTS)
          rd_data_o = rd_offs[0] ? bp_data_o[rd_idx]
                    : xlen_t'({bp_ctrl_o[rd_idx].cc, 2'b00, bp_ctrl_o[rd_idx].enabled, 1'b1});
    endcase
  end

endmodule

/* source/du_access_fsm.sv */
/*
  Debug host port sequencer
  - bank decode and access acceptance
  - acknowledge FSM, frozen by the execute stall
  - single write command into the internal bank
  - registered read data
*/
`timescale 1ns/1ps

module du_access_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dbg_stall_i,
  input  logic                     dbg_strb_i,
  input  logic                     dbg_we_i,
  input  du_map_pkg::du_dbg_addr_t dbg_addr_i,
  input  du_map_pkg::xlen_t        dbg_d_i,
  input  logic                     ex_stall_i,
  input  du_map_pkg::xlen_t        int_rdata_i,
  input  du_map_pkg::xlen_t        npc_i,
  input  du_map_pkg::xlen_t        dpc_i,
  output du_map_pkg::du_wr_t       wr_o,
  output du_map_pkg::xlen_t        dbg_q_o,
  output logic                     dbg_ack_o
);
  import du_map_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT1, WAIT2, ACK} acc_state_t;

  acc_state_t   state_q;
  acc_state_t   state_d;
  du_bank_t     bank;
  du_reg_addr_t reg_addr;
  logic         sel_internal;
  logic         sel_gprs;
  logic         accept;

  ////////////////////////////////////////
  // Address decode
  assign bank         = du_bank_t'(dbg_addr_i[DBG_ADDR_SIZE-1:DU_ADDR_SIZE]);
  assign reg_addr     = dbg_addr_i[DU_ADDR_SIZE-1:0];
  assign sel_internal = (bank == DBG_INTERNAL);
  assign sel_gprs     = (bank == DBG_GPRS);

  // Other banks only while the CPU is halted
  assign accept = dbg_strb_i & (sel_internal | dbg_stall_i);

  ////////////////////////////////////////
  // Acknowledge sequence
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      // No restart while the previous ack is still visible
      IDLE:    if (accept && !dbg_ack_o) state_d = WAIT1;
      WAIT1:   state_d = accept ? WAIT2 : IDLE;
      WAIT2:   state_d = accept ? ACK : IDLE;
      ACK:     state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q   <= IDLE;
      dbg_ack_o <= 1'b0;
      wr_o      <= '0;
    end
    else if (!ex_stall_i)
    begin
      state_q   <= state_d;
      dbg_ack_o <= (state_q == ACK) & accept;
      // One write per access, in the first wait cycle
      wr_o.we   <= (state_q == WAIT1) & accept & sel_internal & dbg_we_i;
      wr_o.addr <= reg_addr;
      wr_o.data <= dbg_d_i;
    end
    else
      wr_o.we <= 1'b0;
  end

  // Read data follows the current address
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dbg_q_o <= '0;
    else if (sel_internal)
      dbg_q_o <= int_rdata_i;
    else if (sel_gprs && reg_addr == DBG_NPC)
      dbg_q_o <= npc_i;
    else if (sel_gprs && reg_addr == DBG_PPC)
      dbg_q_o <= dpc_i;
    else
      dbg_q_o <= '0;
  end

endmodule

/* source/rv_pipe_pkg.sv */
/*
  Observed RISC-V pipeline state
  - major opcodes for branch, load and store
  - instruction, pipeline PC and memory stage structs
  - opcode field extraction
*/
package rv_pipe_pkg;

  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;

  typedef struct packed {
    logic        bubble;
    logic [31:0] instr;
  } insn_t;

  typedef struct packed {
    du_map_pkg::xlen_t if_nxt_pc;
    du_map_pkg::xlen_t pd_pc;
    du_map_pkg::xlen_t id_pc;
    du_map_pkg::xlen_t wb_pc;
  } pipe_pc_t;

  typedef struct packed {
    insn_t             insn;
    du_map_pkg::xlen_t adr;
    logic              ack;
    logic              exc;
  } mem_obs_t;

  // Major opcode lives in instr[6:2]
  function automatic logic [4:0] opcode(input insn_t insn);
    return insn.instr[6:2];
  endfunction

endpackage

/* source/du_map_pkg.sv */
/*
  Debug unit register map and shared types
  - data, address and breakpoint count constants
  - bank codes and internal register addresses
  - breakpoint condition codes and control fields
  - exception vector and internal write command
*/
package du_map_pkg;

  localparam int XLEN            = 32;
  localparam int DBG_ADDR_SIZE   = 16;
  localparam int DU_ADDR_SIZE    = 12;
  localparam int BREAKPOINTS     = 3;
  localparam int MAX_BREAKPOINTS = 8;

  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [DBG_ADDR_SIZE-1:0] du_dbg_addr_t;
  typedef logic [DU_ADDR_SIZE-1:0]  du_reg_addr_t;

  // Upper address nibble selects the bank
  typedef enum logic [DBG_ADDR_SIZE-DU_ADDR_SIZE-1:0] {
    DBG_INTERNAL = 4'h0,
    DBG_GPRS     = 4'h1
  } du_bank_t;

  ////////////////////////////////////////
  // Internal bank
  localparam du_reg_addr_t DBG_CTRL    = 12'h000;
  localparam du_reg_addr_t DBG_HIT     = 12'h001;
  localparam du_reg_addr_t DBG_IE      = 12'h002;
  localparam du_reg_addr_t DBG_CAUSE   = 12'h003;
  // Breakpoint n at these two plus 2n
  localparam du_reg_addr_t DBG_BPCTRL0 = 12'h010;
  localparam du_reg_addr_t DBG_BPDATA0 = 12'h011;

  // GPR bank, program counters
  localparam du_reg_addr_t DBG_NPC     = 12'h200;
  localparam du_reg_addr_t DBG_PPC     = 12'h201;

  typedef enum logic [2:0] {
    BP_CC_FETCH    = 3'h0,
    BP_CC_LD_ADR   = 3'h1,
    BP_CC_ST_ADR   = 3'h2,
    BP_CC_LDST_ADR = 3'h3
  } du_cc_t;

  typedef struct packed {
    logic   enabled;
    du_cc_t cc;
  } bp_ctrl_t;

  typedef logic [BREAKPOINTS-1:0] bp_vec_t;

  // Interrupts in the upper half, traps in the lower half
  typedef struct packed {
    logic [15:0] irq;
    logic [15:0] trap;
  } exc_vec_t;

  typedef struct packed {
    logic         we;
    du_reg_addr_t addr;
    xlen_t        data;
  } du_wr_t;

endpackage
